// ==== vlog.f ====
hw/reg_native_pkg.sv
hw/slv_map_pkg.sv
hw/regdisp_disp_map.sv
hw/regslv_slv_map.sv
hw/reg_subsys_top.sv
verif/tb_clk_gen.sv
verif/tb_reg_subsys.sv

// ==== Makefile ====
# Verilator build and run of the register subsystem testbench
# override any variable on the command line, e.g. make test SEED=7

SIM     ?= verilator
TOP     ?= tb_reg_subsys
FLIST   ?= vlog.f
SEED    ?= 20
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: SIM TOP FLIST SEED OBJ_DIR VFLAGS"

# the simulator exits non-zero on $$fatal, which fails this target
test:
	$(SIM) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_reg_subsys.sv ====
`default_nettype none

module tb_reg_subsys #(
    parameter int SEED = 20
);
    import reg_native_pkg::*;
    import slv_map_pkg::*;

    localparam logic [ADDR_WIDTH-1:0] BASE_ADDR = 48'h0000_4000_0000;
    localparam logic [DATA_WIDTH-1:0] DUMMY_READ_DATA = 32'hDEAD_BEEF;
    localparam int unsigned ACK_WAIT_LIMIT = 8;
    // about 70 accesses of at most 5 cycles each, plus reset, with a wide margin
    localparam int unsigned CYCLE_LIMIT = 2000;

    logic        regdisp_disp_map_clk;
    logic        regdisp_disp_map_rst_n;
    reg_req_t    upstream_req;
    reg_rsp_t    upstream_rsp;
    cfg_fields_t cfg;

    // reference model of the slave registers
    logic [31:0] model_scratch;
    logic [31:0] model_cfg;
    logic [31:0] model_wr_count;
    logic        exp_err;
    logic [31:0] exp_rd_data;

    logic        req_hit;
    logic        req_miss;
    logic [2:0]  hit_dly;
    logic [1:0]  miss_dly;
    logic        exp_ack_vld;
    int unsigned cycle_cnt = 0;
    int          seed;

    tb_clk_gen #(
        .PERIOD     (8),
        .RST_CYCLES (4)
    ) u_clk_gen (
        .clk   (regdisp_disp_map_clk),
        .rst_n (regdisp_disp_map_rst_n)
    );

    reg_subsys_top #(
        .BASE_ADDR          (BASE_ADDR),
        .INSERT_FORWARD_FF  (1),
        .INSERT_BACKWARD_FF (1),
        .DUMMY_READ_DATA    (DUMMY_READ_DATA)
    ) UUT (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .upstream_req           (upstream_req),
        .upstream_rsp           (upstream_rsp),
        .cfg                    (cfg)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic logic addr_in_window(input logic [ADDR_WIDTH-1:0] addr);
        logic [ADDR_WIDTH-1:0] aligned;
        aligned = {addr[ADDR_WIDTH-1:2], 2'b00};
        return (aligned >= BASE_ADDR) && (aligned < BASE_ADDR + ADDR_WIDTH'(SLV_WINDOW_SIZE));
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] reg_addr(input logic [12:0] ofs);
        return BASE_ADDR + ADDR_WIDTH'(ofs);
    endfunction

    // enable in bit 0, mode above it, then threshold, reserved on top
    function automatic cfg_fields_t cfg_view(input logic [31:0] raw);
        cfg_fields_t f;
        f.enable    = raw[0];
        f.mode      = raw[3:1];
        f.threshold = raw[15:4];
        f.reserved  = raw[31:16];
        return f;
    endfunction

    // expected response of one access, and the register update it causes
    task automatic predict_response(input logic [ADDR_WIDTH-1:0] addr, input logic wr,
                                    input logic [31:0] wdata, input logic non_sec);
        logic [12:0] ofs;
        logic        bad;
        logic [31:0] value;
        ofs   = addr[12:0];
        bad   = 1'b0;
        value = '0;
        if (!addr_in_window(addr)) begin
            exp_err     = 1'b0;
            exp_rd_data = DUMMY_READ_DATA;
        end else begin
            case (ofs)
                OFS_ID: begin
                    value = SLV_ID_VALUE;
                    bad   = wr;
                end
                OFS_SCRATCH: value = model_scratch;
                OFS_CFG: begin
                    value = model_cfg;
                    bad   = non_sec;
                end
                OFS_WR_COUNT: begin
                    value = model_wr_count;
                    bad   = wr;
                end
                default: bad = 1'b1;
            endcase
            exp_err     = bad;
            exp_rd_data = (bad || wr) ? 32'h0 : value;
            if (wr && !bad) begin
                if (ofs == OFS_SCRATCH) begin
                    model_scratch = wdata;
                end
                if (ofs == OFS_CFG) begin
                    model_cfg = wdata;
                end
                model_wr_count = model_wr_count + 32'd1;
            end
        end
    endtask

    task automatic issue_access(input logic [ADDR_WIDTH-1:0] addr, input logic wr,
                                input logic [31:0] wdata, input logic non_sec);
        reg_req_t    req;
        int unsigned waited;
        req         = '0;
        req.req_vld = 1'b1;
        req.addr    = addr;
        req.wr_en   = wr;
        req.rd_en   = ~wr;
        req.wr_data = wdata;
        req.non_sec = non_sec;
        @(posedge regdisp_disp_map_clk);
        predict_response(addr, wr, wdata, non_sec);
        upstream_req <= req;
        @(posedge regdisp_disp_map_clk);
        upstream_req <= '0;
        waited = 1;
        while (upstream_rsp.ack_vld !== 1'b1) begin
            if (waited >= ACK_WAIT_LIMIT) begin
                abort_run($sformatf("no ack_vld came back for the access to address %h", addr));
            end
            @(posedge regdisp_disp_map_clk);
            waited++;
        end
    endtask

    task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                             input logic non_sec);
        issue_access(addr, 1'b1, data, non_sec);
    endtask

    task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr, input logic non_sec);
        issue_access(addr, 1'b0, 32'h0, non_sec);
    endtask

    task automatic pulse_soft_rst();
        @(posedge regdisp_disp_map_clk);
        upstream_req.soft_rst <= 1'b1;
        model_scratch  = '0;
        model_cfg      = '0;
        model_wr_count = '0;
        @(posedge regdisp_disp_map_clk);
        upstream_req.soft_rst <= 1'b0;
        // forward stage, then the slave registers clear
        repeat (2) @(posedge regdisp_disp_map_clk);
    endtask

    task automatic check_reset_state();
        assert (upstream_rsp.ack_vld === 1'b0)
            else abort_run($sformatf("Error: upstream_rsp.ack_vld expected %h actual %h",
                                     1'b0, upstream_rsp.ack_vld));
        assert (upstream_rsp.err === 1'b0)
            else abort_run($sformatf("Error: upstream_rsp.err expected %h actual %h",
                                     1'b0, upstream_rsp.err));
        assert (upstream_rsp.rd_data === 32'h0)
            else abort_run($sformatf("Error: upstream_rsp.rd_data expected %h actual %h",
                                     32'h0, upstream_rsp.rd_data));
        assert (cfg === cfg_fields_t'(32'h0))
            else abort_run($sformatf("Error: cfg expected %h actual %h", 32'h0, cfg));
    endtask

    assign req_hit  = upstream_req.req_vld & addr_in_window(upstream_req.addr);
    assign req_miss = upstream_req.req_vld & ~addr_in_window(upstream_req.addr);

    // a hit answers in cycle 3, a miss in cycle 2
    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            hit_dly  <= '0;
            miss_dly <= '0;
        end else begin
            hit_dly  <= {hit_dly[1:0], req_hit};
            miss_dly <= {miss_dly[0], req_miss};
        end
    end

    assign exp_ack_vld = hit_dly[2] | miss_dly[1];

    ack_latency_chk: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n) upstream_rsp.ack_vld == exp_ack_vld)
        else abort_run($sformatf("Error: upstream_rsp.ack_vld expected %h actual %h",
                                 $sampled(exp_ack_vld), $sampled(upstream_rsp.ack_vld)));

    ack_pulse_chk: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n) upstream_rsp.ack_vld |=> !upstream_rsp.ack_vld)
        else abort_run("ack_vld stayed high for more than one cycle");

    err_chk: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n) upstream_rsp.ack_vld |-> upstream_rsp.err == exp_err)
        else abort_run($sformatf("Error: upstream_rsp.err expected %h actual %h",
                                 $sampled(exp_err), $sampled(upstream_rsp.err)));

    rd_data_chk: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n)
        upstream_rsp.ack_vld |-> upstream_rsp.rd_data == exp_rd_data)
        else abort_run($sformatf("Error: upstream_rsp.rd_data expected %h actual %h",
                                 $sampled(exp_rd_data), $sampled(upstream_rsp.rd_data)));

    cfg_chk: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n) upstream_rsp.ack_vld |-> cfg == cfg_view(model_cfg))
        else abort_run($sformatf("Error: cfg expected %h actual %h",
                                 cfg_view($sampled(model_cfg)), $sampled(cfg)));

    always @(posedge regdisp_disp_map_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run("the run went past its cycle limit without finishing");
        end
    end

    initial begin
        logic [31:0] data;
        seed           = SEED;
        model_scratch  = '0;
        model_cfg      = '0;
        model_wr_count = '0;
        exp_err        = 1'b0;
        exp_rd_data    = '0;
        upstream_req  <= '0;
        wait (regdisp_disp_map_rst_n === 1'b1);
        @(posedge regdisp_disp_map_clk);

        check_reset_state();
        read_reg(reg_addr(OFS_ID), 1'b0);
        read_reg(reg_addr(OFS_SCRATCH), 1'b0);
        read_reg(reg_addr(OFS_WR_COUNT), 1'b0);

        for (int i = 0; i < 20; i++) begin
            data = $random(seed);
            write_reg(reg_addr(OFS_SCRATCH), data, 1'b0);
            read_reg(reg_addr(OFS_SCRATCH), 1'b0);
        end
        read_reg(reg_addr(OFS_WR_COUNT), 1'b0);

        // enable set, mode 6, threshold 0x0b5, reserved bits written too
        write_reg(reg_addr(OFS_CFG), 32'h7A3C_0B5D, 1'b0);
        read_reg(reg_addr(OFS_CFG), 1'b0);
        write_reg(reg_addr(OFS_CFG), 32'h0000_0000, 1'b1);
        read_reg(reg_addr(OFS_CFG), 1'b1);
        read_reg(reg_addr(OFS_CFG), 1'b0);
        read_reg(reg_addr(OFS_WR_COUNT), 1'b0);

        write_reg(BASE_ADDR + ADDR_WIDTH'(SLV_WINDOW_SIZE), 32'h1234_5678, 1'b0);
        read_reg(BASE_ADDR + ADDR_WIDTH'(SLV_WINDOW_SIZE), 1'b0);
        read_reg(BASE_ADDR - 48'h4, 1'b1);
        read_reg(48'h0, 1'b0);
        // low bits match the SCRATCH offset
        write_reg(48'hFFFF_0000_0004, 32'hCAFE_0000, 1'b0);
        read_reg(reg_addr(OFS_SCRATCH), 1'b0);
        read_reg(reg_addr(OFS_WR_COUNT), 1'b0);

        read_reg(reg_addr(13'h0100), 1'b0);
        write_reg(reg_addr(13'h0100), 32'h0BAD_0100, 1'b0);
        read_reg(reg_addr(13'h12c4), 1'b0);
        write_reg(reg_addr(OFS_ID), 32'hFFFF_FFFF, 1'b0);
        write_reg(reg_addr(OFS_WR_COUNT), 32'h0000_00FF, 1'b0);
        read_reg(reg_addr(OFS_ID), 1'b0);
        read_reg(reg_addr(OFS_WR_COUNT), 1'b0);

        pulse_soft_rst();
        read_reg(reg_addr(OFS_ID), 1'b0);
        read_reg(reg_addr(OFS_SCRATCH), 1'b0);
        read_reg(reg_addr(OFS_CFG), 1'b0);
        read_reg(reg_addr(OFS_WR_COUNT), 1'b0);

        // let the last ack clear the assertions before ending
        repeat (4) @(posedge regdisp_disp_map_clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned PERIOD = 8,
    parameter int unsigned RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lands right after a rising edge, so no flop sees it mid-cycle
    initial begin
        rst_n <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== hw/reg_subsys_top.sv ====
`default_nettype none

module reg_subsys_top #(
    parameter logic [reg_native_pkg::ADDR_WIDTH-1:0] BASE_ADDR = 48'h0000_4000_0000,
    parameter int unsigned INSERT_FORWARD_FF = 1,
    parameter int unsigned INSERT_BACKWARD_FF = 1,
    parameter logic [reg_native_pkg::DATA_WIDTH-1:0] DUMMY_READ_DATA = 32'hDEAD_BEEF
) (
    input  logic                     regdisp_disp_map_clk,
    input  logic                     regdisp_disp_map_rst_n,
    input  reg_native_pkg::reg_req_t upstream_req,
    output reg_native_pkg::reg_rsp_t upstream_rsp,
    output slv_map_pkg::cfg_fields_t cfg
);
    import reg_native_pkg::*;
    import slv_map_pkg::*;

    reg_req_t slv_req;
    reg_rsp_t slv_rsp;

    // window size and offset width come from the slave's own map
    regdisp_disp_map #(
        .BASE_ADDR          (BASE_ADDR),
        .INSERT_FORWARD_FF  (INSERT_FORWARD_FF),
        .INSERT_BACKWARD_FF (INSERT_BACKWARD_FF),
        .DUMMY_READ_DATA    (DUMMY_READ_DATA),
        .ADDR_REM_BITS      (SLV_ADDR_REM_BITS),
        .WINDOW_SIZE        (SLV_WINDOW_SIZE)
    ) u_regdisp_disp_map (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .upstream_req           (upstream_req),
        .upstream_rsp           (upstream_rsp),
        .slv_req                (slv_req),
        .slv_rsp                (slv_rsp)
    );

    regslv_slv_map u_regslv_slv_map (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .slv_req                (slv_req),
        .slv_rsp                (slv_rsp),
        .cfg                    (cfg)
    );

endmodule

`default_nettype wire

// ==== hw/regslv_slv_map.sv ====
`default_nettype none

module regslv_slv_map (
    input  logic                     regdisp_disp_map_clk,
    input  logic                     regdisp_disp_map_rst_n,
    input  reg_native_pkg::reg_req_t slv_req,
    output reg_native_pkg::reg_rsp_t slv_rsp,
    output slv_map_pkg::cfg_fields_t cfg
);
    import reg_native_pkg::*;
    import slv_map_pkg::*;

    slv_ofs_t  ofs;
    logic      sel_id;
    logic      sel_scratch;
    logic      sel_cfg;
    logic      sel_wr_count;
    logic      acc_err;
    logic      wr_ok;
    data_t     rd_mux;
    reg_rsp_t  rsp_d;

    data_t     scratch_q;
    cfg_word_u cfg_q;
    data_t     wr_count_q;

    // upper address bits are zero, the dispatcher already cut them
    assign ofs = slv_req.addr[SLV_ADDR_REM_BITS-1:0];

    always_comb begin
        sel_id       = 1'b0;
        sel_scratch  = 1'b0;
        sel_cfg      = 1'b0;
        sel_wr_count = 1'b0;
        case (ofs)
            OFS_ID:       sel_id = 1'b1;
            OFS_SCRATCH:  sel_scratch = 1'b1;
            OFS_CFG:      sel_cfg = 1'b1;
            OFS_WR_COUNT: sel_wr_count = 1'b1;
            default: begin
            end
        endcase
    end

    // unknown offset, write to a read-only register, or non-secure CFG access
    assign acc_err = ~(sel_id | sel_scratch | sel_cfg | sel_wr_count) |
                     (slv_req.wr_en & (sel_id | sel_wr_count)) |
                     (slv_req.non_sec & sel_cfg);

    assign wr_ok = slv_req.req_vld & slv_req.wr_en & ~acc_err;

    always_comb begin
        rd_mux = '0;
        case (1'b1)
            sel_id:       rd_mux = SLV_ID_VALUE;
            sel_scratch:  rd_mux = scratch_q;
            sel_cfg:      rd_mux = cfg_q.raw;
            sel_wr_count: rd_mux = wr_count_q;
            default: begin
            end
        endcase
    end

    // soft_rst wins over a write in the same cycle
    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            scratch_q  <= RST_SCRATCH;
            cfg_q.raw  <= RST_CFG;
            wr_count_q <= RST_WR_COUNT;
        end else if (slv_req.soft_rst) begin
            scratch_q  <= RST_SCRATCH;
            cfg_q.raw  <= RST_CFG;
            wr_count_q <= RST_WR_COUNT;
        end else if (wr_ok) begin
            if (sel_scratch) begin
                scratch_q <= slv_req.wr_data;
            end
            if (sel_cfg) begin
                cfg_q.raw <= slv_req.wr_data;
            end
            wr_count_q <= wr_count_q + 1'b1;
        end
    end

    // rd_data stays zero outside a good read so idle cycles are quiet
    always_comb begin
        rsp_d.ack_vld = slv_req.req_vld;
        rsp_d.err     = slv_req.req_vld & acc_err;
        if (slv_req.req_vld && slv_req.rd_en && !acc_err) begin
            rsp_d.rd_data = rd_mux;
        end else begin
            rsp_d.rd_data = '0;
        end
    end

    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            slv_rsp <= '0;
        end else begin
            slv_rsp <= rsp_d;
        end
    end

    assign cfg = cfg_q.fields;

endmodule

`default_nettype wire

// ==== hw/regdisp_disp_map.sv ====
`default_nettype none

module regdisp_disp_map #(
    parameter logic [reg_native_pkg::ADDR_WIDTH-1:0] BASE_ADDR = '0,
    parameter int unsigned INSERT_FORWARD_FF = 0,
    parameter int unsigned INSERT_BACKWARD_FF = 0,
    parameter logic [reg_native_pkg::DATA_WIDTH-1:0] DUMMY_READ_DATA = '0,
    parameter int unsigned ADDR_REM_BITS = 13,
    parameter int unsigned WINDOW_SIZE = 32'h12c8
) (
    input  logic                     regdisp_disp_map_clk,
    input  logic                     regdisp_disp_map_rst_n,
    input  reg_native_pkg::reg_req_t upstream_req,
    output reg_native_pkg::reg_rsp_t upstream_rsp,
    output reg_native_pkg::reg_req_t slv_req,
    input  reg_native_pkg::reg_rsp_t slv_rsp
);
    import reg_native_pkg::*;

    // decode works on word addresses, byte lanes are ignored
    localparam int unsigned ALIGN_BITS = $clog2(DATA_WIDTH / 8);
    localparam int unsigned WORD_BITS = ADDR_WIDTH - ALIGN_BITS;
    localparam logic [ADDR_WIDTH-1:0] WIN_BASE = BASE_ADDR;
    localparam logic [ADDR_WIDTH-1:0] WIN_END = BASE_ADDR + ADDR_WIDTH'(WINDOW_SIZE);

    logic [WORD_BITS-1:0] word_addr;
    logic                 in_window;
    logic                 dec_hit;
    logic                 dec_miss;
    reg_req_t             fwd_req;
    logic                 dummy_ack_q;
    reg_rsp_t             bwd_rsp;

    assign word_addr = upstream_req.addr[ADDR_WIDTH-1:ALIGN_BITS];
    assign in_window = (word_addr >= WIN_BASE[ADDR_WIDTH-1:ALIGN_BITS]) &&
                       (word_addr < WIN_END[ADDR_WIDTH-1:ALIGN_BITS]);

    assign dec_hit  = upstream_req.req_vld & in_window;
    assign dec_miss = upstream_req.req_vld & ~in_window;

    // route a hit to the slave with the address cut down to its offset
    // soft_rst goes through even when nothing decodes
    always_comb begin
        fwd_req          = '0;
        fwd_req.soft_rst = upstream_req.soft_rst;
        if (dec_hit) begin
            fwd_req.req_vld = 1'b1;
            fwd_req.addr    = ADDR_WIDTH'(upstream_req.addr[ADDR_REM_BITS-1:0]);
            fwd_req.wr_en   = upstream_req.wr_en;
            fwd_req.rd_en   = upstream_req.rd_en;
            fwd_req.wr_data = upstream_req.wr_data;
            fwd_req.non_sec = upstream_req.non_sec;
        end
    end

    generate
        if (INSERT_FORWARD_FF != 0) begin : g_fwd_ff
            always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
                if (!regdisp_disp_map_rst_n) begin
                    slv_req <= '0;
                end else begin
                    slv_req <= fwd_req;
                end
            end
        end else begin : g_fwd_wire
            assign slv_req = fwd_req;
        end
    endgenerate

    // dummy register answers a miss one cycle later
    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            dummy_ack_q <= 1'b0;
        end else begin
            dummy_ack_q <= dec_miss;
        end
    end

    // only one request is ever in flight, so the two acks never collide
    always_comb begin
        bwd_rsp.ack_vld = slv_rsp.ack_vld | dummy_ack_q;
        if (dummy_ack_q) begin
            bwd_rsp.err     = 1'b0;
            bwd_rsp.rd_data = DUMMY_READ_DATA;
        end else begin
            bwd_rsp.err     = slv_rsp.err;
            bwd_rsp.rd_data = slv_rsp.rd_data;
        end
    end

    generate
        if (INSERT_BACKWARD_FF != 0) begin : g_bwd_ff
            always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
                if (!regdisp_disp_map_rst_n) begin
                    upstream_rsp <= '0;
                end else begin
                    upstream_rsp <= bwd_rsp;
                end
            end
        end else begin : g_bwd_wire
            assign upstream_rsp = bwd_rsp;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hw/slv_map_pkg.sv ====
`default_nettype none

package slv_map_pkg;

    // the slave only decodes the low address bits
    parameter int unsigned SLV_ADDR_REM_BITS = 13;

    // bytes covered by the slave window, starting at the dispatcher base
    parameter int unsigned SLV_WINDOW_SIZE = 32'h12c8;

    typedef logic [SLV_ADDR_REM_BITS-1:0] slv_ofs_t;

    // register offsets inside the window
    parameter slv_ofs_t OFS_ID       = 13'h0000;
    parameter slv_ofs_t OFS_SCRATCH  = 13'h0004;
    parameter slv_ofs_t OFS_CFG      = 13'h0008;
    parameter slv_ofs_t OFS_WR_COUNT = 13'h1000;

    // fixed identification word
    parameter logic [31:0] SLV_ID_VALUE = 32'h5EC0_0001;

    // values after reset and after soft_rst
    parameter logic [31:0] RST_SCRATCH  = 32'h0000_0000;
    parameter logic [31:0] RST_CFG      = 32'h0000_0000;
    parameter logic [31:0] RST_WR_COUNT = 32'h0000_0000;

    // CFG layout, enable sits in bit 0
    typedef struct packed {
        logic [15:0] reserved;
        logic [11:0] threshold;
        logic [2:0]  mode;
        logic        enable;
    } cfg_fields_t;

    // bus side sees the raw word, the top level sees the fields
    typedef union packed {
        logic [31:0] raw;
        cfg_fields_t fields;
    } cfg_word_u;

endpackage

`default_nettype wire

// ==== hw/reg_native_pkg.sv ====
`default_nettype none

package reg_native_pkg;

    // absolute byte address seen by the upstream master
    parameter int unsigned ADDR_WIDTH = 48;

    // one register word
    parameter int unsigned DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // native request, req_vld is a single-cycle strobe
    // exactly one of wr_en and rd_en is set while req_vld is high
    // soft_rst is a level and travels regardless of req_vld
    typedef struct packed {
        logic  req_vld;
        addr_t addr;
        logic  wr_en;
        logic  rd_en;
        data_t wr_data;
        logic  non_sec;
        logic  soft_rst;
    } reg_req_t;

    // native response
    // err and rd_data only mean something in the ack_vld cycle
    typedef struct packed {
        logic  ack_vld;
        logic  err;
        data_t rd_data;
    } reg_rsp_t;

endpackage

`default_nettype wire
